// ==== jpeg_entropy_pkg.sv ====
`default_nettype none

package jpeg_entropy_pkg;

    localparam int COEF_W          = 11;  // quantized coefficient
    localparam int LANES           = 2;   // coefficients per beat
    localparam int BEATS_PER_BLOCK = 32;
    localparam int CODE_W          = 16;  // longest huffman code
    localparam int LANE_W          = 26;  // code + magnitude, one lane
    localparam int WORD_W          = 52;  // both lanes joined

    typedef enum logic [1:0] {
        COMP_Y,
        COMP_CB,
        COMP_CR
    } comp_t;

    typedef struct packed {
        logic [LANES-1:0][COEF_W-1:0] coef;      // lane 0 first in zigzag order
        logic [4:0]                   cnt;       // beat 0..31, dc in lane 0 of beat 0
        comp_t                        comp;
        logic                         last_mcu;  // every beat of the final block
    } coef_beat_t;

    typedef struct packed {
        logic [5:0]        len;   // valid bits in bits
        logic [WORD_W-1:0] bits;  // left aligned
        logic              last;  // closes the image
    } codeword_t;

    // rom entry {len[4:0], code[15:0]}, code right aligned, len 0 means no code
    typedef logic [20:0] rom_t [256];

    // annex K, counts of codes per length 1..16, length 1 in the top byte
    localparam logic [127:0] DC_LUMA_BITS   = 128'h00010501010101010100000000000000;
    localparam logic [127:0] DC_CHROMA_BITS = 128'h00030101010101010101010000000000;
    localparam logic [127:0] AC_LUMA_BITS   = 128'h0002010303020403050504040000017d;
    localparam logic [127:0] AC_CHROMA_BITS = 128'h00020102040403040705040400010277;

    localparam logic [95:0] DC_VALS = 96'h000102030405060708090a0b;  // both dc tables

    // symbols in code order, first symbol in the top byte
    localparam logic [1295:0] AC_LUMA_VALS = {
        128'h01020300041105122131410613516107, 128'h227114328191a1082342b1c11552d1f0,
        128'h2433627282090a161718191a25262728, 128'h292a3435363738393a43444546474849,
        128'h4a535455565758595a63646566676869, 128'h6a737475767778797a83848586878889,
        128'h8a92939495969798999aa2a3a4a5a6a7, 128'ha8a9aab2b3b4b5b6b7b8b9bac2c3c4c5,
        128'hc6c7c8c9cad2d3d4d5d6d7d8d9dae1e2, 128'he3e4e5e6e7e8e9eaf1f2f3f4f5f6f7f8,
        16'hf9fa
    };
    localparam logic [1295:0] AC_CHROMA_VALS = {
        128'h00010203110405213106124151076171, 128'h1322328108144291a1b1c109233352f0,
        128'h156272d10a162434e125f11718191a26, 128'h2728292a35363738393a434445464748,
        128'h494a535455565758595a636465666768, 128'h696a737475767778797a828384858687,
        128'h88898a92939495969798999aa2a3a4a5, 128'ha6a7a8a9aab2b3b4b5b6b7b8b9bac2c3,
        128'hc4c5c6c7c8c9cad2d3d4d5d6d7d8d9da, 128'he2e3e4e5e6e7e8e9eaf2f3f4f5f6f7f8,
        16'hf9fa
    };

    // canonical code assignment, as in annex C
    function automatic rom_t build_rom(input logic [127:0] bits, input logic [1295:0] vals,
                                       input int nvals);
        rom_t        r;
        logic [15:0] code;
        int          k;
        code = '0;
        k    = 0;
        for (int a = 0; a < 256; a++)
            r[a] = '0;
        for (int l = 1; l <= 16; l++) begin
            for (int n = 0; n < int'(bits[(16-l)*8 +: 8]); n++) begin
                r[vals[(nvals-1-k)*8 +: 8]] = {5'(l), code};
                code++;
                k++;
            end
            code = code << 1;  // next length
        end
        return r;
    endfunction

    localparam rom_t DC_LUMA_ROM   = build_rom(DC_LUMA_BITS, 1296'(DC_VALS), 12);
    localparam rom_t DC_CHROMA_ROM = build_rom(DC_CHROMA_BITS, 1296'(DC_VALS), 12);
    localparam rom_t AC_LUMA_ROM   = build_rom(AC_LUMA_BITS, AC_LUMA_VALS, 162);
    localparam rom_t AC_CHROMA_ROM = build_rom(AC_CHROMA_BITS, AC_CHROMA_VALS, 162);

    localparam logic [7:0] SYM_EOB = 8'h00;
    localparam logic [7:0] SYM_ZRL = 8'hf0;  // sixteen zeros

endpackage

`default_nettype wire

// ==== huff_tables.sv ====
`timescale 1ns/10ps
`default_nettype none

module huff_tables (
    input  wire logic             clk,
    input  wire logic [1:0][3:0]  run,     // zero run before the coefficient
    input  wire logic [1:0][3:0]  size,    // magnitude category
    input  wire logic [1:0]       ac,      // 0 selects the dc table
    input  wire logic [1:0]       chroma,
    input  wire logic [1:0]       re,
    output logic      [1:0][15:0] code,    // right aligned
    output logic      [1:0][4:0]  len
);
    import jpeg_entropy_pkg::*;

    logic [7:0]  sym [LANES];
    logic [20:0] ent [LANES];

    // symbol decode and table select, per lane
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sym[i] = ac[i] ? {run[i], size[i]} : {4'h0, size[i]};  // dc indexed by size only
            case ({ac[i], chroma[i]})
                2'b00:   ent[i] = DC_LUMA_ROM[sym[i]];
                2'b01:   ent[i] = DC_CHROMA_ROM[sym[i]];
                2'b10:   ent[i] = AC_LUMA_ROM[sym[i]];
                default: ent[i] = AC_CHROMA_ROM[sym[i]];
            endcase
        end
    end

    // registered read, holds while re is low
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (re[i]) begin
                len[i]  <= ent[i][20:16];
                code[i] <= ent[i][15:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== entropy.sv ====
`timescale 1ns/10ps
`default_nettype none

module entropy (
    input  wire logic                         clk,
    input  wire logic                         resetn,
    input  wire jpeg_entropy_pkg::coef_beat_t beat,
    input  wire logic                         beat_valid,
    output logic                              beat_hold,
    output jpeg_entropy_pkg::codeword_t       cw,
    output logic                              cw_valid,
    input  wire logic                         cw_hold
);
    import jpeg_entropy_pkg::*;

    typedef struct packed {
        logic              v;
        logic [COEF_W-1:0] mag;   // one's complement for negatives
        logic [3:0]        size;
    } coef_slot_t;

    typedef struct packed {
        logic              v;
        logic [CODE_W-1:0] code;  // right aligned
        logic [4:0]        clen;
        logic [COEF_W-1:0] mag;
        logic [3:0]        size;
    } slot_t;

    logic take;
    logic end_blk;

    logic signed [COEF_W-1:0] pred [3];  // dc predictor per component
    logic [3:0]               run_q;     // zeros since last code
    logic [1:0]               zrl_q;     // pending groups of 16

    logic [3:0]              run_c [LANES+1];
    logic [1:0]              zrl_c [LANES+1];
    logic signed [COEF_W:0]  val_c [LANES];
    logic [3:0]              size_c [LANES];
    logic [COEF_W-1:0]       mag_c [LANES];
    logic [LANES-1:0]        emit;
    logic [1:0]              zins;       // zrls to slip in ahead of this beat

    logic [LANES-1:0][3:0]        hrun, hsize;
    logic [LANES-1:0]             hac, hchroma;
    logic [LANES-1:0][CODE_W-1:0] hcode;
    logic [LANES-1:0][4:0]        hlen;

    logic [20:0] zrl_ent;
    slot_t       zslot;

    coef_slot_t            s0 [LANES];
    slot_t                 s1 [LANES];
    slot_t                 s2 [LANES];
    logic [LANE_W-1:0]     lw_c [LANES];
    logic [4:0]            ll_c [LANES];
    logic [LANE_W-1:0]     lw3 [LANES];
    logic [4:0]            ll3 [LANES];
    logic [LANES-1:0]      v3;
    logic [3:0]            last_q;       // last flag, one bit per stage
    logic [5:0]            tot_c;
    logic [WORD_W-1:0]     word_c;

    assign beat_hold = cw_hold;  // whole pipe stalls together
    assign take      = beat_valid & ~cw_hold;
    assign end_blk   = beat.cnt == 5'(BEATS_PER_BLOCK-1);

    // magnitude category, bit length of |v|
    function automatic logic [3:0] cat_of(input logic signed [COEF_W:0] v);
        logic [COEF_W:0] a;
        logic [3:0]      n;
        a = v[COEF_W] ? -v : v;
        n = '0;
        for (int b = 0; b <= COEF_W; b++)
            if (a[b])
                n = 4'(b + 1);
        return n;
    endfunction

    // dpcm, run length and symbol choice for both lanes
    always_comb begin
        logic is_dc;
        logic is_end;
        logic [COEF_W:0] m;
        run_c[0] = run_q;
        zrl_c[0] = zrl_q;
        zins     = '0;
        for (int i = 0; i < LANES; i++) begin
            is_dc  = (i == 0) && (beat.cnt == '0);
            is_end = (i == LANES-1) && end_blk;
            val_c[i] = is_dc ? $signed(beat.coef[i]) - pred[beat.comp] : $signed(beat.coef[i]);
            size_c[i] = cat_of(val_c[i]);
            m = val_c[i][COEF_W] ? val_c[i] - 1 : val_c[i];  // negative -> one's complement
            mag_c[i] = m[COEF_W-1:0] & ~({COEF_W{1'b1}} << size_c[i]);
            emit[i]  = 1'b0;
            hrun[i]  = run_c[i];
            hsize[i] = size_c[i];
            hac[i]     = ~is_dc;
            hchroma[i] = beat.comp != COMP_Y;
            run_c[i+1] = run_c[i] + 4'd1;
            zrl_c[i+1] = zrl_c[i];
            if (is_dc) begin
                emit[i]    = 1'b1;
                hrun[i]    = '0;
                run_c[i+1] = '0;
                zrl_c[i+1] = '0;
            end else if (beat.coef[i] != '0) begin
                emit[i]    = 1'b1;
                zins       = zins | zrl_c[i];  // flush pending zrls first
                run_c[i+1] = '0;
                zrl_c[i+1] = '0;
            end else if (is_end) begin
                emit[i]    = 1'b1;           // eob, pending zrls dropped
                {hrun[i], hsize[i]} = SYM_EOB;
                run_c[i+1] = '0;
                zrl_c[i+1] = '0;
            end else if (run_c[i] == 4'd15) begin
                run_c[i+1] = '0;             // sixteenth zero
                zrl_c[i+1] = zrl_c[i] + 2'd1;
            end
        end
    end

    assign zrl_ent = (beat.comp == COMP_Y) ? AC_LUMA_ROM[SYM_ZRL] : AC_CHROMA_ROM[SYM_ZRL];
    assign zslot   = '{v: 1'b1, code: zrl_ent[15:0], clen: zrl_ent[20:16], mag: '0, size: '0};

    huff_tables i_huff (
        .clk    (clk),
        .run    (hrun),
        .size   (hsize),
        .ac     (hac),
        .chroma (hchroma),
        .re     ({LANES{~cw_hold}}),
        .code   (hcode),
        .len    (hlen)
    );

    // run state and dc predictors
    always_ff @(posedge clk) begin
        if (!resetn) begin
            run_q <= '0;
            zrl_q <= '0;
            for (int c = 0; c < 3; c++)
                pred[c] <= '0;
        end else if (take) begin
            run_q <= run_c[LANES];
            zrl_q <= zrl_c[LANES];
            if (beat.last_mcu && end_blk) begin
                for (int c = 0; c < 3; c++)
                    pred[c] <= '0;           // next image starts absolute
            end else if (beat.cnt == '0) begin
                pred[beat.comp] <= $signed(beat.coef[0]);
            end
        end
    end

    // join code and magnitude per lane, left aligned in 26 bits
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            ll_c[i] = s2[i].v ? s2[i].clen + 5'(s2[i].size) : '0;
            lw_c[i] = '0;
            if (s2[i].v)
                lw_c[i] = ({s2[i].code, 10'b0} << (CODE_W - s2[i].clen))
                        | (LANE_W'(s2[i].mag) << (LANE_W - ll_c[i]));
        end
    end

    // both lanes into one word, lane 0 first
    assign tot_c  = 6'(ll3[0]) + 6'(ll3[1]);
    assign word_c = {lw3[0], {LANE_W{1'b0}}} | ({lw3[1], {LANE_W{1'b0}}} >> ll3[0]);

    // five stage pipe, frozen by cw_hold
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < LANES; i++) begin
                s0[i].v <= 1'b0;
                s1[i].v <= 1'b0;
                s2[i].v <= 1'b0;
            end
            v3       <= '0;
            last_q   <= '0;
            cw_valid <= 1'b0;
        end else if (!cw_hold) begin
            for (int i = 0; i < LANES; i++) begin
                s0[i] <= '{v: take & emit[i], mag: mag_c[i], size: size_c[i]};
                s1[i] <= '{s0[i].v, hcode[i], hlen[i], s0[i].mag, s0[i].size};  // code from rom
                if (take && zins[1])
                    s1[i] <= zslot;          // two zrls, slots are idle behind a zero run
                s2[i]  <= s1[i];
                lw3[i] <= lw_c[i];
                ll3[i] <= ll_c[i];
                v3[i]  <= s2[i].v;
            end
            if (take && zins[0])
                s2[LANES-1] <= zslot;        // one zrl
            last_q   <= {last_q[2:0], take & beat.last_mcu & end_blk};
            cw_valid <= |v3;
            cw       <= '{len: tot_c, bits: word_c, last: last_q[3]};
        end
    end

endmodule

`default_nettype wire

// ==== bit_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_packer (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    input  wire jpeg_entropy_pkg::codeword_t cw,
    input  wire logic                        cw_valid,
    output logic                             cw_hold,
    output logic [7:0]                       byte_data,
    output logic                             byte_valid,
    output logic                             byte_last,
    input  wire logic                        byte_hold
);
    import jpeg_entropy_pkg::*;

    logic [63:0] acc;    // left aligned, zeros past cnt
    logic [6:0]  cnt;    // unsent bits
    logic        flush;  // draining after a last word
    logic        stuff;  // 0x00 owed after an 0xff

    // room for a full word only at 12 bits or less
    assign cw_hold = byte_hold | (cnt > 7'd12) | flush;

    always_ff @(posedge clk) begin
        logic [63:0] a;
        logic [6:0]  n;
        logic [2:0]  pad;
        if (!resetn) begin
            acc        <= '0;
            cnt        <= '0;
            flush      <= 1'b0;
            stuff      <= 1'b0;
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
        end else if (!byte_hold) begin
            a = acc;
            n = cnt;
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
            if (stuff) begin
                byte_data  <= 8'h00;         // stuffed byte, cycle of its own
                byte_valid <= 1'b1;
                stuff      <= 1'b0;
                if (flush && n == '0) begin
                    byte_last <= 1'b1;
                    flush     <= 1'b0;
                end
            end else if (n >= 7'd8) begin
                byte_data  <= a[63:56];
                byte_valid <= 1'b1;
                stuff      <= a[63:56] == 8'hff;
                if (flush && n == 7'd8 && a[63:56] != 8'hff) begin
                    byte_last <= 1'b1;       // nothing follows
                    flush     <= 1'b0;
                end
                a = a << 8;
                n = n - 7'd8;
            end
            // append after the byte left, so the word lands behind what remains
            if (cw_valid && !cw_hold) begin
                a = a | ({cw.bits, {(64-WORD_W){1'b0}}} >> n);
                n = n + 7'(cw.len);
                if (cw.last) begin
                    pad = 3'(8 - n[2:0]);    // ones up to the byte edge
                    a = a | ((~64'b0 >> n) & ~(~64'b0 >> (n + 7'(pad))));
                    n = n + 7'(pad);
                    flush <= 1'b1;
                end
            end
            acc <= a;
            cnt <= n;
        end
    end

endmodule

`default_nettype wire

// ==== jpeg_entropy_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module jpeg_entropy_top (
    input  wire logic                         clk,
    input  wire logic                         resetn,
    input  wire jpeg_entropy_pkg::coef_beat_t in_beat,
    input  wire logic                         in_valid,
    output logic                              in_hold,
    output logic [7:0]                        byte_data,
    output logic                              byte_valid,
    output logic                              byte_last,
    input  wire logic                         byte_hold
);
    import jpeg_entropy_pkg::*;

    codeword_t cw;        // packed code words
    logic      cw_valid;
    logic      cw_hold;   // packer back-pressure, also stalls the input

    entropy i_entropy (
        .clk        (clk),
        .resetn     (resetn),
        .beat       (in_beat),
        .beat_valid (in_valid),
        .beat_hold  (in_hold),
        .cw         (cw),
        .cw_valid   (cw_valid),
        .cw_hold    (cw_hold)
    );

    bit_packer i_packer (
        .clk        (clk),
        .resetn     (resetn),
        .cw         (cw),
        .cw_valid   (cw_valid),
        .cw_hold    (cw_hold),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_last  (byte_last),
        .byte_hold  (byte_hold)
    );

endmodule

`default_nettype wire

// ==== tb_jpeg_entropy.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_jpeg_entropy;
    import jpeg_entropy_pkg::*;

    localparam int MAX_BLK = 16;
    localparam int MAX_TST = 8;

    logic       clk;
    logic       resetn;
    coef_beat_t in_beat;
    logic       in_valid;
    logic       in_hold;
    logic [7:0] byte_data;
    logic       byte_valid;
    logic       byte_last;
    logic       byte_hold;

    // stimulus table with blocks as full zigzag arrays
    int           coef_tab [MAX_BLK][64];
    comp_t        comp_tab [MAX_BLK];
    logic         last_tab [MAX_BLK];
    int           nblk;
    string        name_tab [MAX_TST];
    int           blk_first [MAX_TST];
    int           blk_cnt [MAX_TST];
    logic [127:0] exp_tab [MAX_TST];   // expected stream with the first byte leftmost
    int           exp_cnt [MAX_TST];
    int           ntst;

    int          cur;                  // test in flight
    int          got;                  // bytes taken so far in this test
    int          test_errors;
    int          errors;
    int          failed_tests;
    int          cycles;
    int          limit;
    int          base_limit;
    int          beats_total;
    int          bytes_total;
    bit          random_hold;          // sink stalls at random

    jpeg_entropy_top i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_hold    (in_hold),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_last  (byte_last),
        .byte_hold  (byte_hold)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic begin_test(input string name, input int n, input logic [127:0] bytes);
        name_tab[ntst]  = name;
        blk_first[ntst] = nblk;
        blk_cnt[ntst]   = 0;
        exp_cnt[ntst]   = n;
        exp_tab[ntst]   = bytes;   // n bytes right aligned
        ntst++;
    endtask

    task automatic add_block(input comp_t c, input logic last, input int dc);
        for (int k = 0; k < 64; k++)
            coef_tab[nblk][k] = 0;
        coef_tab[nblk][0] = dc;
        comp_tab[nblk]    = c;
        last_tab[nblk]    = last;
        blk_cnt[ntst-1]++;
        nblk++;
    endtask

    task automatic set_coef(input int idx, input int val);
        coef_tab[nblk-1][idx] = val;
    endtask

    function automatic logic [7:0] expected_byte(input int t, input int k);
        return exp_tab[t][(exp_cnt[t]-1-k)*8 +: 8];
    endfunction

    // bytes worked out by hand from the annex K codes
    task automatic build_table();
        begin_test("dc only", 2, 128'h96bf);             // 100 101, eob 1010, pad
        add_block(COMP_Y, 1'b1, 5);
        begin_test("dpcm per component", 4, 128'hb55258ca);
        add_block(COMP_Y, 1'b0, 10);                     // diff 10
        add_block(COMP_CB, 1'b0, -2);                    // diff -2, chroma table
        add_block(COMP_CR, 1'b0, 3);
        add_block(COMP_Y, 1'b1, 7);                      // diff -3 against 10
        begin_test("new image codes dc absolute", 2, 128'h9ebf);
        add_block(COMP_Y, 1'b1, 7);
        begin_test("runs of 0 15 16 zeros", 7, 128'h0fff00abfcb57f);
        add_block(COMP_Y, 1'b1, 0);
        set_coef(1, 1);                                  // 0/1
        set_coef(17, -1);                                // f/1
        set_coef(34, 2);                                 // zrl then 0/2, long tail
        begin_test("run of 35 zeros and negatives", 6, 128'h3fcff9e9157f);
        add_block(COMP_Y, 1'b1, 0);
        set_coef(36, -1);                                // two zrls then 3/1
        set_coef(37, -5);                                // bits 010
        begin_test("both lanes in one beat", 2, 128'h5789);
        add_block(COMP_CR, 1'b1, -1);
        set_coef(2, 1);                                  // run from lane 1 into lane 0
        set_coef(3, -2);
        begin_test("0xff stuffing", 5, 128'h24ff0026bf);
        add_block(COMP_Y, 1'b1, 0);
        set_coef(1, 4);                                  // byte aligned before zrl
        set_coef(18, 1);
    endtask

    // one beat per accepted cycle
    task automatic send_block(input int b);
        logic held;
        for (int c = 0; c < BEATS_PER_BLOCK; c++) begin
            in_beat.coef[0]  = COEF_W'(coef_tab[b][2*c]);
            in_beat.coef[1]  = COEF_W'(coef_tab[b][2*c+1]);
            in_beat.cnt      = 5'(c);
            in_beat.comp     = comp_tab[b];
            in_beat.last_mcu = last_tab[b];
            in_valid         = 1'b1;
            do begin
                @(negedge clk);
                held = in_hold;                          // decides the coming edge
                @(posedge clk);
                #1;
            end while (held);
        end
    endtask

    task automatic run_test(input int t);
        cur         = t;
        got         = 0;
        test_errors = 0;
        for (int b = 0; b < blk_cnt[t]; b++)
            send_block(blk_first[t] + b);
        in_valid = 1'b0;
        while (got < exp_cnt[t])
            @(posedge clk);
        repeat (4) @(posedge clk);                       // room for stray bytes
        #1;
        $display("test %0d %s, %s: %s", t, name_tab[t],
                 random_hold ? "random sink stalls" : "no stalls",
                 (test_errors == 0) ? "ok" : "errors");
        errors += test_errors;
        if (test_errors != 0)
            failed_tests++;
    endtask

    task automatic check_byte();
        assert (got < exp_cnt[cur]) else begin
            $display("unexpected byte 0x%02h after the end of the stream in test %0d",
                     byte_data, cur);
            test_errors++;
        end
        if (got < exp_cnt[cur]) begin
            assert (byte_data == expected_byte(cur, got)) else begin
                $display("mismatch byte_data at byte %0d: expected 0x%02h, actual 0x%02h",
                         got, expected_byte(cur, got), byte_data);
                test_errors++;
            end
            assert (byte_last == (got == exp_cnt[cur] - 1)) else begin
                if (byte_last)
                    $display("byte_last came early, on byte %0d of %0d", got, exp_cnt[cur]);
                else
                    $display("byte_last missing on the final byte %0d", got);
                test_errors++;
            end
            got++;
        end
    endtask

    // outputs settle mid cycle and the byte moves at the next edge
    always @(negedge clk) begin
        if (resetn && byte_valid && !byte_hold)
            check_byte();
    end

    initial begin
        void'($urandom(32'h30d));
        forever begin
            @(posedge clk);
            #1 byte_hold = random_hold ? 1'($urandom % 2) : 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, test %0d got %0d bytes", cycles, cur, got);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_beat      = '0;
        byte_hold    = 1'b0;
        random_hold  = 1'b0;
        nblk         = 0;
        ntst         = 0;
        cur          = 0;
        got          = 0;
        test_errors  = 0;
        errors       = 0;
        failed_tests = 0;
        cycles       = 0;
        limit        = 0;
        bytes_total  = 0;
        build_table();
        beats_total = nblk * BEATS_PER_BLOCK;
        for (int t = 0; t < ntst; t++)
            bytes_total += exp_cnt[t];
        base_limit = 4 * (beats_total + bytes_total) + 200;
        limit      = base_limit + 2 * base_limit;        // plain pass then stalled pass
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;
        for (int pass = 0; pass < 2; pass++) begin
            random_hold = (pass == 1);
            for (int t = 0; t < ntst; t++)
                run_test(t);
        end
        $display("tests run %0d, tests with errors %0d, errors %0d",
                 2 * ntst, failed_tests, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
jpeg_entropy_pkg.sv
huff_tables.sv
entropy.sv
bit_packer.sv
jpeg_entropy_top.sv
tb_jpeg_entropy.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_jpeg_entropy -f filelist.f -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
